/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tpu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
verilog/tpu_pkg.sv
verilog/wb_host_port.sv
verilog/unified_buffer.sv
verilog/weight_store.sv
verilog/ub_read_control.sv
verilog/mac_lane.sv
verilog/result_collector.sv
verilog/tpu_core.sv
test/tpu_properties.sv
test/tb_tpu.sv

/* test/tb_tpu.sv */
module tb_tpu;
    import tpu_pkg::*;

    localparam int          LANES        = 4;
    localparam int          BUS_TIMEOUT  = 200;
    localparam int          DONE_TIMEOUT = 100;
    localparam logic [1:0]  REGION_UB    = 2'd0;
    localparam logic [1:0]  REGION_W     = 2'd1;
    localparam logic [1:0]  REGION_RES   = 2'd3;
    localparam logic [13:0] ADR_INSTR    = {2'd2, 12'd0};

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [13:0] wb_adr;
    logic [31:0] wb_dat_wr;
    logic [31:0] wb_dat_rd;
    logic        wb_ack;
    logic        busy;

    logic [31:0] lfsr_q;
    string       test_name;
    int          error_count;
    int          timeout_count;
    int          ack_wait;

    // Reference copies of what the host has written, and the expected result memory
    logic signed [ELEM_W-1:0] x_mem [2**UB_AW];
    logic signed [ELEM_W-1:0] w_mem [2**DIM_W][LANES];
    logic [ACC_W-1:0]         exp_res [2**DIM_W][LANES];

    tpu_core #(.LANES(LANES)) dut (
        .clk_i(clk), .rst_i(rst),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_wr),
        .wb_dat_o(wb_dat_rd), .wb_ack_o(wb_ack), .busy_o(busy)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[6:0], fb};
        end
        return v;
    endfunction

    task automatic end_run();
        $display("Checks with errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic check_result(input string what, input logic [ACC_W-1:0] expected,
                                input logic [ACC_W-1:0] actual);
        if (actual !== expected) begin
            $display("Error in %s, %s: expected %0d, actual %0d", test_name, what,
                     $signed(expected), $signed(actual));
            error_count++;
        end
    endtask

    // Status is {done, busy}
    task automatic check_status(input string what, input logic [1:0] expected,
                                input logic [1:0] actual);
        if (actual !== expected) begin
            $display("Error in %s, %s: expected %b, actual %b", test_name, what,
                     expected, actual);
            error_count++;
        end
    endtask

    task automatic check_wait(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error in %s, %s: expected %0d cycles, actual %0d cycles", test_name,
                     what, expected, actual);
            error_count++;
        end
    endtask

    // Bus tasks start right after a rising edge and leave one idle cycle behind them
    task automatic wb_write(input logic [13:0] adr, input logic [31:0] dat);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_we     <= 1'b1;
        wb_adr    <= adr;
        wb_dat_wr <= dat;
        while (!got && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            got = wb_ack;
            cycles++;
            @(posedge clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        ack_wait = cycles;
        @(posedge clk);
        if (!got) begin
            $display("Timeout in %s: write to address %h was never acknowledged",
                     test_name, adr);
            timeout_count++;
            end_run();
        end
    endtask

    task automatic wb_read(input logic [13:0] adr, output logic [31:0] dat);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        dat    = '0;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        while (!got && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            got = wb_ack;
            dat = wb_dat_rd;
            cycles++;
            @(posedge clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(posedge clk);
        if (!got) begin
            $display("Timeout in %s: read of address %h was never acknowledged",
                     test_name, adr);
            timeout_count++;
            end_run();
        end
    endtask

    task automatic wait_done();
        logic [31:0] d;
        int          polls;
        d     = '0;
        polls = 0;
        while (!d[1] && polls < DONE_TIMEOUT) begin
            wb_read(ADR_INSTR, d);
            polls++;
        end
        if (!d[1]) begin
            $display("Timeout in %s: the done flag was never set", test_name);
            timeout_count++;
            end_run();
        end
    endtask

    task automatic write_elem(input int addr, input logic [7:0] val);
        wb_write({REGION_UB, 12'(addr)}, {24'd0, val});
        x_mem[addr] = val;
    endtask

    task automatic write_weight(input int k, input int j, input logic [7:0] val);
        wb_write({REGION_W, 12'(k * LANES + j)}, {24'd0, val});
        w_mem[k][j] = val;
    endtask

    // result[r][j] is the sum over k of x[start + r * depth + k] * w[k][j]
    task automatic run_model(input int start, input int depth, input int rows);
        logic signed [ACC_W-1:0] acc;
        for (int r = 0; r < rows; r++) begin
            for (int j = 0; j < LANES; j++) begin
                acc = '0;
                for (int k = 0; k < depth; k++) begin
                    acc = acc + x_mem[start + r * depth + k] * w_mem[k][j];
                end
                exp_res[r][j] = acc;
            end
        end
    endtask

    task automatic issue_instr(input opcode_e op, input int start, input int depth,
                               input int rows);
        instr_t ins;
        ins.opcode     = op;
        ins.start_addr = UB_AW'(start);
        ins.depth_m1   = DIM_W'(depth - 1);
        ins.rows_m1    = DIM_W'(rows - 1);
        ins.spare      = '0;
        if (op == OP_MATMUL) begin
            run_model(start, depth, rows);
        end
        wb_write(ADR_INSTR, ins);
    endtask

    task automatic read_results(input int rows);
        logic [31:0] d;
        for (int r = 0; r < rows; r++) begin
            for (int j = 0; j < LANES; j++) begin
                wb_read({REGION_RES, 12'(r * LANES + j)}, d);
                check_result($sformatf("row %0d lane %0d", r, j), exp_res[r][j], d);
            end
        end
    endtask

    task automatic load_random(input int start, input int count, input int depth);
        for (int i = 0; i < count; i++) begin
            write_elem(start + i, rand_byte());
        end
        for (int k = 0; k < depth; k++) begin
            for (int j = 0; j < LANES; j++) begin
                write_weight(k, j, rand_byte());
            end
        end
    endtask

    task automatic test_single();
        logic [31:0]             d;
        logic signed [ACC_W-1:0] prod;
        test_name = "single element";
        load_random(0, 1, 1);
        issue_instr(OP_MATMUL, 0, 1, 1);
        wait_done();
        for (int j = 0; j < LANES; j++) begin
            prod = x_mem[0] * w_mem[0][j];
            wb_read({REGION_RES, 12'(j)}, d);
            check_result($sformatf("lane %0d product", j), prod, d);
        end
    endtask

    task automatic test_random();
        test_name = "random 4x8";
        load_random(100, 32, 8);
        issue_instr(OP_MATMUL, 100, 8, 4);
        wait_done();
        read_results(4);
    endtask

    task automatic test_status();
        logic [31:0] d;
        test_name = "status";
        wb_read(ADR_INSTR, d);
        check_status("done kept from last run", 2'b10, d[1:0]);
        issue_instr(OP_MATMUL, 100, 8, 4);
        @(negedge clk);
        check_status("busy output", 2'b01, {1'b0, busy});
        @(posedge clk);
        wb_read(ADR_INSTR, d);
        check_status("done cleared while running", 2'b01, d[1:0]);
        wait_done();
        wb_read(ADR_INSTR, d);
        check_status("done after run", 2'b10, d[1:0]);
        read_results(4);
    endtask

    // Second instruction covers fewer rows, so row 2 still holds the first one's sums
    task automatic test_chain();
        test_name = "chained";
        load_random(200, 12, 5);
        for (int i = 0; i < 10; i++) begin
            write_elem(300 + i, rand_byte());
        end
        issue_instr(OP_MATMUL, 200, 4, 3);
        check_wait("first ack", 1, ack_wait);
        issue_instr(OP_MATMUL, 300, 5, 2);
        // The ack comes with the first run's twelfth read and the request starts after its first
        check_wait("second ack", 3 * 4 - 1, ack_wait);
        wait_done();
        read_results(3);
    endtask

    // The NOP carries a large size so that running it would show up as busy
    task automatic test_nop();
        logic [31:0] d;
        test_name = "nop";
        issue_instr(OP_NOP, 0, 8, 4);
        check_wait("nop ack", 1, ack_wait);
        wb_read(ADR_INSTR, d);
        check_status("status after nop", 2'b10, d[1:0]);
        read_results(3);
    endtask

    task automatic test_extreme();
        logic [31:0] d;
        test_name = "depth 64 extreme";
        for (int i = 0; i < 64; i++) begin
            write_elem(512 + i, 8'h80);
            for (int j = 0; j < LANES; j++) begin
                write_weight(i, j, 8'h80);
            end
        end
        issue_instr(OP_MATMUL, 512, 64, 1);
        wait_done();
        read_results(1);
        for (int j = 0; j < LANES; j++) begin
            wb_read({REGION_RES, 12'(j)}, d);
            check_result($sformatf("lane %0d exact sum", j), 64 * 128 * 128, d);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_wr     = '0;
        lfsr_q        = 32'h424a_e2b8;
        error_count   = 0;
        timeout_count = 0;
        ack_wait      = 0;
        test_name     = "reset";
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_single();
        test_random();
        test_status();
        test_chain();
        test_nop();
        test_extreme();
        end_run();
    end

endmodule

/* test/tpu_properties.sv */
module tpu_properties (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      ack_i,
    input logic                      ready_i,
    input logic                      re_i,
    input logic                      first_i,
    input logic [tpu_pkg::DIM_W-1:0] row_i,
    input logic [tpu_pkg::UB_AW-1:0] raddr_i
);

    // Each transfer is acknowledged in a single cycle
    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
        else $error("Acknowledge stayed high for more than one cycle");

    // Elements of a row sit at consecutive buffer addresses
    addr_step: assert property (@(posedge clk_i) disable iff (rst_i)
        re_i && !first_i |-> raddr_i == $past(raddr_i) + 1'b1)
        else $error("Buffer read address did not advance by one within a row");

    // A waiting instruction is taken only with the final read of a run,
    // so the next cycle is idle or reads row 0 of the new run
    ready_at_run_end: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i && re_i |=> !re_i || (first_i && row_i == '0))
        else $error("Instruction taken before the final read of the running one");

endmodule

bind wb_host_port tpu_properties u_host_props (
    .clk_i(clk_i), .rst_i(rst_i), .ack_i(wb_ack_o),
    .ready_i(1'b0), .re_i(1'b0), .first_i(1'b0), .row_i('0), .raddr_i('0)
);

bind ub_read_control tpu_properties u_ctrl_props (
    .clk_i(clk_i), .rst_i(rst_i), .ack_i(1'b0),
    .ready_i(instr_ready_o), .re_i(ub_re_o), .first_i(ctrl_o.first),
    .row_i(ctrl_o.row), .raddr_i(ub_raddr_o)
);

/* verilog/mac_lane.sv */
module mac_lane (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  tpu_pkg::lane_ctrl_t        ctrl_i,
    input  logic [tpu_pkg::ELEM_W-1:0] elem_i,
    input  logic [tpu_pkg::ELEM_W-1:0] weight_i,
    output logic [tpu_pkg::ACC_W-1:0]  sum_o,
    output logic                       sum_valid_o
);
    import tpu_pkg::*;

    logic signed [2*ELEM_W-1:0] prod;
    logic signed [ACC_W-1:0]    prod_ext;
    logic signed [ACC_W-1:0]    acc_q;

    assign prod     = $signed(elem_i) * $signed(weight_i);
    assign prod_ext = prod;

    // The first element of a row starts a fresh sum
    always_ff @(posedge clk_i) begin
        if (ctrl_i.valid) begin
            acc_q <= ctrl_i.first ? prod_ext : acc_q + prod_ext;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= ctrl_i.valid & ctrl_i.last;
        end
    end

    assign sum_o = acc_q;

endmodule

/* verilog/result_collector.sv */
module result_collector #(
    parameter int LANES  = 4,
    parameter int RES_AW = 8
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             start_i,
    input  logic                             busy_i,
    input  logic [LANES-1:0]                 sum_valid_i,
    input  logic [LANES*tpu_pkg::ACC_W-1:0]  sums_i,
    input  logic [tpu_pkg::DIM_W-1:0]        row_i,
    input  logic [RES_AW-1:0]                raddr_i,
    output logic [tpu_pkg::ACC_W-1:0]        rdata_o,
    output logic                             done_o
);
    import tpu_pkg::*;

    logic [LANES-1:0][ACC_W-1:0] mem [2**DIM_W];
    logic [DIM_W-1:0]            row_q;
    logic                        busy_q;
    logic                        row_wr;
    logic [DIM_W-1:0]            rd_row;
    logic [RES_AW-1:0]           rd_lane;

    // Sums come out one cycle after the lanes saw the row's last element
    always_ff @(posedge clk_i) begin
        row_q <= row_i;
    end

    assign row_wr = &sum_valid_i;

    always_ff @(posedge clk_i) begin
        if (row_wr) begin
            mem[row_q] <= sums_i;
        end
    end

    // Host address is row * LANES + lane
    assign rd_row  = DIM_W'(raddr_i / RES_AW'(LANES));
    assign rd_lane = raddr_i % RES_AW'(LANES);

    always_ff @(posedge clk_i) begin
        rdata_o <= mem[rd_row][rd_lane];
    end

    // Busy as it was in the cycle right after the row's last read
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy_i;
        end
    end

    // The controller keeps reading after a row's last read unless that row is the final one
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_o <= 1'b0;
        end else if (start_i) begin
            done_o <= 1'b0;
        end else if (row_wr && !busy_q) begin
            done_o <= 1'b1;
        end
    end

endmodule

/* verilog/tpu_core.sv */
module tpu_core #(
    parameter int LANES  = 4,
    parameter int RES_AW = tpu_pkg::DIM_W + $clog2(LANES)
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [13:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        busy_o
);
    import tpu_pkg::*;

    localparam int W_AW = DIM_W + $clog2(LANES);

    logic                    instr_valid;
    logic                    instr_ready;
    instr_t                  instr;
    logic                    ub_we;
    logic [UB_AW-1:0]        ub_waddr;
    logic [ELEM_W-1:0]       ub_wdata;
    logic                    ub_re;
    logic [UB_AW-1:0]        ub_raddr;
    logic [ELEM_W-1:0]       ub_rdata;
    logic                    w_we;
    logic [W_AW-1:0]         w_addr;
    logic [ELEM_W-1:0]       w_data;
    lane_ctrl_t              rd_ctrl;
    lane_ctrl_t              lane_ctrl;
    logic [LANES*ELEM_W-1:0] weights;
    logic [LANES*ACC_W-1:0]  sums;
    logic [LANES-1:0]        sum_valid;
    logic [RES_AW-1:0]       res_addr;
    logic [ACC_W-1:0]        res_data;
    logic                    done;
    logic                    start;

    wb_host_port #(.LANES(LANES), .RES_AW(RES_AW)) u_host (
        .clk_i(clk_i), .rst_i(rst_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .instr_ready_i(instr_ready), .res_data_i(res_data),
        .busy_i(busy_o), .done_i(done),
        .ub_we_o(ub_we), .ub_waddr_o(ub_waddr), .ub_wdata_o(ub_wdata),
        .w_we_o(w_we), .w_addr_o(w_addr), .w_data_o(w_data),
        .instr_valid_o(instr_valid), .instr_o(instr), .res_addr_o(res_addr)
    );

    unified_buffer u_ub (
        .clk_i(clk_i), .we_i(ub_we), .waddr_i(ub_waddr), .wdata_i(ub_wdata),
        .re_i(ub_re), .raddr_i(ub_raddr), .rdata_o(ub_rdata)
    );

    weight_store #(.LANES(LANES)) u_weights (
        .clk_i(clk_i), .we_i(w_we), .addr_i(w_addr), .data_i(w_data),
        .ctrl_i(rd_ctrl), .ctrl_o(lane_ctrl), .weights_o(weights)
    );

    ub_read_control u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_valid_i(instr_valid), .instr_i(instr), .instr_ready_o(instr_ready),
        .ub_re_o(ub_re), .ub_raddr_o(ub_raddr), .ctrl_o(rd_ctrl),
        .busy_o(busy_o), .start_o(start)
    );

    // Every lane sees the same element and its own weight
    for (genvar j = 0; j < LANES; j++) begin : g_lane
        mac_lane u_lane (
            .clk_i(clk_i), .rst_i(rst_i), .ctrl_i(lane_ctrl),
            .elem_i(ub_rdata), .weight_i(weights[j*ELEM_W +: ELEM_W]),
            .sum_o(sums[j*ACC_W +: ACC_W]), .sum_valid_o(sum_valid[j])
        );
    end

    result_collector #(.LANES(LANES), .RES_AW(RES_AW)) u_collect (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start), .busy_i(busy_o),
        .sum_valid_i(sum_valid), .sums_i(sums), .row_i(lane_ctrl.row),
        .raddr_i(res_addr), .rdata_o(res_data), .done_o(done)
    );

endmodule

/* verilog/tpu_pkg.sv */
package tpu_pkg;

    // Signed width of input elements and weights
    localparam int ELEM_W = 8;
    // Lane accumulators and results are wide enough for 64 products of -128 * -128
    localparam int ACC_W = 32;
    localparam int UB_AW = 10;
    // Dimension fields hold a count minus one, giving 1 to 64
    localparam int DIM_W = 6;

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_MATMUL = 2'd1
    } opcode_e;

    // Instruction word as written by the host into region 2
    typedef struct packed {
        opcode_e          opcode;
        logic [UB_AW-1:0] start_addr;
        logic [DIM_W-1:0] depth_m1;
        logic [DIM_W-1:0] rows_m1;
        logic [7:0]       spare;
    } instr_t;

    // Per-element control that travels alongside each buffer read
    typedef struct packed {
        logic             valid;
        logic             first;
        logic             last;
        logic [DIM_W-1:0] k;
        logic [DIM_W-1:0] row;
    } lane_ctrl_t;

endpackage

/* verilog/ub_read_control.sv */
module ub_read_control (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      instr_valid_i,
    input  tpu_pkg::instr_t           instr_i,
    output logic                      instr_ready_o,
    output logic                      ub_re_o,
    output logic [tpu_pkg::UB_AW-1:0] ub_raddr_o,
    output tpu_pkg::lane_ctrl_t       ctrl_o,
    output logic                      busy_o,
    output logic                      start_o
);
    import tpu_pkg::*;

    typedef enum logic {
        IDLE,
        READ
    } state_e;

    state_e           state_q;
    logic [UB_AW-1:0] addr_q;
    logic [DIM_W-1:0] k_q;
    logic [DIM_W-1:0] row_q;
    logic [DIM_W-1:0] depth_m1_q;
    logic [DIM_W-1:0] rows_m1_q;
    logic             reading;
    logic             row_end;
    logic             last_read;

    assign reading   = (state_q == READ);
    assign row_end   = reading & (k_q == depth_m1_q);
    assign last_read = row_end & (row_q == rows_m1_q);

    // A waiting instruction is taken when idle or while the final read issues
    assign instr_ready_o = instr_valid_i & (~reading | last_read);
    assign start_o       = instr_ready_o & (instr_i.opcode == OP_MATMUL);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            addr_q     <= '0;
            k_q        <= '0;
            row_q      <= '0;
            depth_m1_q <= '0;
            rows_m1_q  <= '0;
        end else if (start_o) begin
            state_q    <= READ;
            addr_q     <= instr_i.start_addr;
            k_q        <= '0;
            row_q      <= '0;
            depth_m1_q <= instr_i.depth_m1;
            rows_m1_q  <= instr_i.rows_m1;
        end else if (reading) begin
            // Rows are packed back to back, so the address just keeps counting
            addr_q <= addr_q + 1'b1;
            if (last_read) begin
                state_q <= IDLE;
            end else if (row_end) begin
                k_q   <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                k_q <= k_q + 1'b1;
            end
        end
    end

    assign ub_re_o    = reading;
    assign ub_raddr_o = addr_q;
    assign busy_o     = reading;

    always_comb begin
        ctrl_o.valid = reading;
        ctrl_o.first = reading & (k_q == '0);
        ctrl_o.last  = row_end;
        ctrl_o.k     = k_q;
        ctrl_o.row   = row_q;
    end

endmodule

/* verilog/unified_buffer.sv */
module unified_buffer (
    input  logic                       clk_i,
    input  logic                       we_i,
    input  logic [tpu_pkg::UB_AW-1:0]  waddr_i,
    input  logic [tpu_pkg::ELEM_W-1:0] wdata_i,
    input  logic                       re_i,
    input  logic [tpu_pkg::UB_AW-1:0]  raddr_i,
    output logic [tpu_pkg::ELEM_W-1:0] rdata_o
);
    import tpu_pkg::*;

    logic [ELEM_W-1:0] mem [2**UB_AW];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // The element appears the cycle after re_i
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

/* verilog/wb_host_port.sv */
module wb_host_port #(
    parameter int LANES  = 4,
    parameter int RES_AW = 8
) (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      wb_cyc_i,
    input  logic                                      wb_stb_i,
    input  logic                                      wb_we_i,
    input  logic [13:0]                               wb_adr_i,
    input  logic [31:0]                               wb_dat_i,
    output logic [31:0]                               wb_dat_o,
    output logic                                      wb_ack_o,
    input  logic                                      instr_ready_i,
    input  logic [tpu_pkg::ACC_W-1:0]                 res_data_i,
    input  logic                                      busy_i,
    input  logic                                      done_i,
    output logic                                      ub_we_o,
    output logic [tpu_pkg::UB_AW-1:0]                 ub_waddr_o,
    output logic [tpu_pkg::ELEM_W-1:0]                ub_wdata_o,
    output logic                                      w_we_o,
    output logic [tpu_pkg::DIM_W+$clog2(LANES)-1:0]   w_addr_o,
    output logic [tpu_pkg::ELEM_W-1:0]                w_data_o,
    output logic                                      instr_valid_o,
    output tpu_pkg::instr_t                           instr_o,
    output logic [RES_AW-1:0]                         res_addr_o
);
    import tpu_pkg::*;

    localparam logic [1:0] REGION_UB     = 2'd0;
    localparam logic [1:0] REGION_WEIGHT = 2'd1;
    localparam logic [1:0] REGION_INSTR  = 2'd2;
    localparam logic [1:0] REGION_RESULT = 2'd3;

    logic [1:0]  region;
    logic        req;
    logic        wr_ack;
    logic        rd_start;
    logic        rd_ack_q;
    logic        sel_res_q;
    logic [31:0] rd_q;

    assign region = wb_adr_i[13:12];
    assign req    = wb_cyc_i & wb_stb_i;

    // Writes land in the same cycle as the strobe
    assign ub_we_o    = req & wb_we_i & (region == REGION_UB);
    assign ub_waddr_o = wb_adr_i[UB_AW-1:0];
    assign ub_wdata_o = wb_dat_i[ELEM_W-1:0];
    assign w_we_o     = req & wb_we_i & (region == REGION_WEIGHT);
    assign w_addr_o   = wb_adr_i[DIM_W+$clog2(LANES)-1:0];
    assign w_data_o   = wb_dat_i[ELEM_W-1:0];

    // The master keeps the cycle open until ack, so the request stays pending
    // until the controller takes it
    assign instr_valid_o = req & wb_we_i & (region == REGION_INSTR);
    assign instr_o       = instr_t'(wb_dat_i);

    // Instruction writes wait for the controller, all other writes ack at once
    assign wr_ack = req & wb_we_i & ((region != REGION_INSTR) | instr_ready_i);

    assign rd_start   = req & ~wb_we_i & ~rd_ack_q;
    assign res_addr_o = wb_adr_i[RES_AW-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ack_q  <= 1'b0;
            sel_res_q <= 1'b0;
        end else begin
            rd_ack_q <= rd_start;
            if (rd_start) begin
                sel_res_q <= (region == REGION_RESULT);
            end
        end
    end

    // Status is sampled in the strobe cycle, result data comes from the collector
    always_ff @(posedge clk_i) begin
        if (rd_start) begin
            rd_q <= (region == REGION_INSTR) ? {30'd0, done_i, busy_i} : 32'd0;
        end
    end

    assign wb_ack_o = wr_ack | rd_ack_q;
    assign wb_dat_o = sel_res_q ? res_data_i : rd_q;

endmodule

/* verilog/weight_store.sv */
module weight_store #(
    parameter int LANES = 4
) (
    input  logic                                    clk_i,
    input  logic                                    we_i,
    input  logic [tpu_pkg::DIM_W+$clog2(LANES)-1:0] addr_i,
    input  logic [tpu_pkg::ELEM_W-1:0]              data_i,
    input  tpu_pkg::lane_ctrl_t                     ctrl_i,
    output tpu_pkg::lane_ctrl_t                     ctrl_o,
    output logic [LANES*tpu_pkg::ELEM_W-1:0]        weights_o
);
    import tpu_pkg::*;

    localparam int W_AW = DIM_W + $clog2(LANES);

    // One row per reduction index, holding the weight of every lane
    logic [LANES-1:0][ELEM_W-1:0] mem [2**DIM_W];
    logic [DIM_W-1:0]             wr_k;
    logic [W_AW-1:0]              wr_lane;

    assign wr_k    = DIM_W'(addr_i / W_AW'(LANES));
    assign wr_lane = addr_i % W_AW'(LANES);

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[wr_k][wr_lane] <= data_i;
        end
    end

    // Weights and control leave together, in step with the buffer's registered read
    always_ff @(posedge clk_i) begin
        weights_o <= mem[ctrl_i.k];
        ctrl_o    <= ctrl_i;
    end

endmodule
